//--- fetch_realign_top.f
hdl/realign_pkg.sv
hdl/instr_realign.sv
hdl/instr_queue.sv
hdl/fetch_realign_top.sv
verification/tb_clk_gen.sv
verification/tb_fetch_realign.sv

//--- Bender.yml
package:
  name: fetch_realign

sources:
  - hdl/realign_pkg.sv
  - hdl/instr_realign.sv
  - hdl/instr_queue.sv
  - hdl/fetch_realign_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_fetch_realign.sv

//--- verification/tb_fetch_realign.sv
// directed testbench for the fetch re-aligner, checked against a model of the alignment rules
`timescale 1ns/10ps

module tb_fetch_realign;

    localparam int unsigned QueueDepth    = 8;
    localparam bit          EnableRvc     = 1'b1;
    localparam int unsigned TimeoutCycles = 200;
    // behavior of the consumer on the output port
    localparam int ReadyAlways = 0;
    localparam int ReadyHold   = 1;
    localparam int ReadyStall  = 2;

    logic                      clk;
    logic                      rst_n;
    logic                      flush;
    logic                      fetch_valid;
    realign_pkg::fetch_req_t   fetch_req;
    logic                      fetch_ready;
    logic                      instr_valid;
    realign_pkg::instr_entry_t instr;
    logic                      instr_ready;

    int unsigned checks     = 0;
    int unsigned errors     = 0;
    int          ready_mode = ReadyAlways;
    bit          stall_pattern [64];

    // expected output stream and the model's own pending half
    realign_pkg::instr_entry_t expected_q [$];
    logic                      model_pending = 1'b0;
    realign_pkg::half_t        model_half;
    realign_pkg::addr_t        model_addr;

    tb_clk_gen #(
        .PeriodNs    (8),
        .ResetCycles (4)
    ) i_clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    fetch_realign_top #(
        .QueueDepth (QueueDepth),
        .EnableRvc  (EnableRvc)
    ) dut (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .flush_i       (flush),
        .fetch_valid_i (fetch_valid),
        .fetch_req_i   (fetch_req),
        .fetch_ready_o (fetch_ready),
        .instr_valid_o (instr_valid),
        .instr_o       (instr),
        .instr_ready_i (instr_ready)
    );

    // --------------------
    // checking and end of run
    // --------------------

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    // --------------------
    // reference model
    // --------------------

    function automatic bit is_compressed(input realign_pkg::half_t parcel);
        return EnableRvc && (parcel[1:0] != 2'b11);
    endfunction

    // applies the alignment rules to one accepted beat and queues what must come out
    task automatic apply_rules(input realign_pkg::addr_t addr,
                               input realign_pkg::fetch_word_t data);
        realign_pkg::half_t lower;
        realign_pkg::half_t upper;
        bit                 take_upper;
        lower      = data[15:0];
        upper      = data[31:16];
        take_upper = 1'b1;
        if (addr[1]) begin
            // after a jump into the upper half the lower parcel is not ours
            take_upper = 1'b0;
            model_pending = !is_compressed(upper);
            model_half    = upper;
            model_addr    = addr;
            if (is_compressed(upper)) begin
                expected_q.push_back('{addr: addr, instr: {16'h0, upper}});
            end
        end else if (model_pending) begin
            expected_q.push_back('{addr: model_addr, instr: {lower, model_half}});
        end else if (is_compressed(lower)) begin
            expected_q.push_back('{addr: addr, instr: {16'h0, lower}});
        end else begin
            take_upper    = 1'b0;
            model_pending = 1'b0;
            expected_q.push_back('{addr: addr, instr: data});
        end
        // the upper parcel at A+2 is either a compressed instruction or a new first half
        if (take_upper) begin
            model_pending = !is_compressed(upper);
            model_half    = upper;
            model_addr    = {addr[63:2], 2'b10};
            if (is_compressed(upper)) begin
                expected_q.push_back('{addr: model_addr, instr: {16'h0, upper}});
            end
        end
    endtask

    // the collector first compares the popped head and then the model adds this edge's beat
    always @(posedge clk) begin : track_stream
        realign_pkg::instr_entry_t head;
        if (!rst_n || flush) begin
            expected_q.delete();
            model_pending = 1'b0;
        end else begin
            if (instr_valid && instr_ready) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("unexpected instruction %h at address %h, nothing was expected",
                             instr.instr, instr.addr);
                end else begin
                    head = expected_q.pop_front();
                    check_value("instruction address", instr.addr, head.addr);
                    check_value("instruction word", instr.instr, head.instr);
                end
            end
            if (fetch_valid && fetch_ready) begin
                apply_rules(fetch_req.addr, fetch_req.data);
            end
        end
    end

    // the consumer side is driven on the rising edge from the pre-drawn stall pattern
    initial begin : drive_ready
        int unsigned stall_idx;
        stall_idx   = 0;
        instr_ready = 1'b0;
        forever begin
            @(posedge clk);
            if (ready_mode == ReadyHold) begin
                instr_ready <= 1'b0;
            end else if (ready_mode == ReadyStall) begin
                instr_ready <= stall_pattern[stall_idx % 64];
                stall_idx++;
            end else begin
                instr_ready <= 1'b1;
            end
        end
    end

    // --------------------
    // stimulus helpers
    // --------------------

    function automatic realign_pkg::instr_t rand_full();
        return realign_pkg::instr_t'($urandom) | 32'h3;
    endfunction

    function automatic realign_pkg::half_t rand_rvc();
        realign_pkg::half_t parcel;
        parcel = realign_pkg::half_t'($urandom);
        // one of the three compressed quadrants
        parcel[1:0] = 2'($urandom % 3);
        return parcel;
    endfunction

    // presents one beat and returns on the edge that takes it
    task automatic send_beat(input realign_pkg::addr_t addr,
                             input realign_pkg::fetch_word_t data);
        int unsigned waited;
        waited = 0;
        fetch_valid    <= 1'b1;
        fetch_req.addr <= addr;
        fetch_req.data <= data;
        @(posedge clk);
        while (!fetch_ready && waited < TimeoutCycles) begin
            waited++;
            @(posedge clk);
        end
        if (!fetch_ready) begin
            errors++;
            $display("timeout: beat at address %h was never accepted", addr);
            finish_run();
        end
    endtask

    task automatic stop_fetch();
        fetch_valid <= 1'b0;
    endtask

    // waits until every expected entry came out and the DUT holds nothing more
    task automatic wait_drained(input string what);
        int unsigned waited;
        waited = 0;
        @(negedge clk);
        while ((expected_q.size() != 0 || instr_valid) && waited < TimeoutCycles) begin
            waited++;
            @(negedge clk);
        end
        if (expected_q.size() != 0 || instr_valid) begin
            errors++;
            $display("timeout: %s still has %0d instructions missing", what, expected_q.size());
            finish_run();
        end
        @(posedge clk);
    endtask

    task automatic flush_path();
        flush       <= 1'b1;
        fetch_valid <= 1'b0;
        @(negedge clk);
        check_value("fetch_ready during flush", fetch_ready, 1'b0);
        @(posedge clk);
        flush <= 1'b0;
    endtask

    // --------------------
    // directed tests
    // --------------------

    task automatic full_word_stream();
        for (int i = 0; i < 4; i++) begin
            send_beat(64'h8000_0000 + 4 * i, rand_full());
        end
        stop_fetch();
        wait_drained("full word stream");
    endtask

    task automatic compressed_pairs();
        for (int i = 0; i < 3; i++) begin
            send_beat(64'h8000_1000 + 4 * i, {rand_rvc(), rand_rvc()});
        end
        stop_fetch();
        wait_drained("compressed pairs");
    endtask

    // the full instruction begins at A+2 and ends in the next word
    task automatic spanning_instr();
        realign_pkg::instr_t span;
        span = rand_full();
        send_beat(64'h8000_2000, {span[15:0], rand_rvc()});
        send_beat(64'h8000_2004, {rand_rvc(), span[31:16]});
        stop_fetch();
        wait_drained("spanning instruction");
    endtask

    task automatic branch_entry();
        realign_pkg::instr_t span;
        realign_pkg::instr_t skipped;
        span    = rand_full();
        skipped = rand_full();
        send_beat(64'h8000_3002, {rand_rvc(), skipped[15:0]});
        send_beat(64'h8000_4006, {span[15:0], skipped[31:16]});
        send_beat(64'h8000_4008, {rand_rvc(), span[31:16]});
        stop_fetch();
        wait_drained("branch entry");
    endtask

    task automatic queue_back_pressure();
        realign_pkg::fetch_word_t held_word;
        realign_pkg::instr_t      span;
        ready_mode <= ReadyHold;
        // one full word and three compressed pairs leave a single entry free
        send_beat(64'h8000_5000, rand_full());
        for (int i = 1; i < 4; i++) begin
            send_beat(64'h8000_5000 + 4 * i, {rand_rvc(), rand_rvc()});
        end
        held_word      = {rand_rvc(), rand_rvc()};
        fetch_req.addr <= 64'h8000_5010;
        fetch_req.data <= held_word;
        repeat (4) begin
            @(negedge clk);
            check_value("fetch_ready with one free entry", fetch_ready, 1'b0);
        end
        @(posedge clk);
        ready_mode <= ReadyStall;
        send_beat(64'h8000_5010, held_word);
        span = rand_full();
        send_beat(64'h8000_5014, {span[15:0], rand_rvc()});
        send_beat(64'h8000_5018, {rand_rvc(), span[31:16]});
        send_beat(64'h8000_501c, rand_full());
        stop_fetch();
        wait_drained("back pressure");
    endtask

    task automatic flush_mid_stream();
        realign_pkg::instr_t span;
        span       = rand_full();
        ready_mode <= ReadyHold;
        send_beat(64'h8000_6000, {rand_rvc(), rand_rvc()});
        send_beat(64'h8000_6004, {span[15:0], rand_rvc()});
        flush_path();
        ready_mode <= ReadyAlways;
        // a stale half would be glued onto this lower parcel
        send_beat(64'h8000_7000, {rand_rvc(), rand_rvc()});
        stop_fetch();
        wait_drained("flush");
    endtask

    initial begin : run_tests
        int unsigned waited;
        void'($urandom(32'h453));
        for (int i = 0; i < 64; i++) begin
            stall_pattern[i] = ($urandom % 3) != 0;
        end
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_req   = '0;
        waited      = 0;
        while (rst_n !== 1'b1 && waited < TimeoutCycles) begin
            waited++;
            @(posedge clk);
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("reset was never released");
            finish_run();
        end
        @(negedge clk);
        check_value("instr_valid after reset", instr_valid, 1'b0);
        check_value("fetch_ready after reset", fetch_ready, 1'b1);
        @(posedge clk);
        full_word_stream();
        compressed_pairs();
        spanning_instr();
        branch_entry();
        queue_back_pressure();
        flush_mid_stream();
        finish_run();
    end

endmodule

//--- verification/tb_clk_gen.sv
// testbench clock and reset source with a fixed period and reset length
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int unsigned PeriodNs    = 8,
    parameter int unsigned ResetCycles = 4
) (
    output logic clk_o,
    output logic rst_no
);

    // free running clock that starts low
    initial begin
        clk_o = 1'b0;
        forever #(PeriodNs / 2) clk_o = ~clk_o;
    end

    // reset is held for a fixed number of rising edges and released on an edge
    initial begin
        rst_no = 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

//--- hdl/fetch_realign_top.sv
// fetch re-alignment top level joining the re-aligner and the instruction queue
`timescale 1ns/10ps

module fetch_realign_top #(
    parameter int unsigned QueueDepth = 8,
    parameter bit          EnableRvc  = 1'b1
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  logic                      fetch_valid_i,
    input  realign_pkg::fetch_req_t   fetch_req_i,
    output logic                      fetch_ready_o,
    output logic                      instr_valid_o,
    output realign_pkg::instr_entry_t instr_o,
    input  logic                      instr_ready_i
);

    // --------------------
    // fetch handshake
    // --------------------

    // high when the queue can absorb a whole word of two instructions
    logic queue_space;
    // a beat is consumed on this edge
    logic fetch_accept;

    // no beat is taken while the path is being flushed
    assign fetch_ready_o = queue_space && !flush_i;
    assign fetch_accept  = fetch_valid_i && fetch_ready_o;

    // slot bundle from the re-aligner into the queue
    logic [realign_pkg::InstrPerFetch-1:0]                      slot_valid;
    realign_pkg::instr_entry_t [realign_pkg::InstrPerFetch-1:0] slot;

    // --------------------
    // sub-blocks
    // --------------------

    instr_realign #(
        .EnableRvc (EnableRvc)
    ) i_instr_realign (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .fetch_accept_i (fetch_accept),
        .fetch_req_i    (fetch_req_i),
        .slot_valid_o   (slot_valid),
        .slot_o         (slot)
    );

    // the accept qualifies the slots so they are only written on a taken beat
    instr_queue #(
        .QueueDepth (QueueDepth)
    ) i_instr_queue (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .push_i        (fetch_accept),
        .slot_valid_i  (slot_valid),
        .slot_i        (slot),
        .space_o       (queue_space),
        .instr_valid_o (instr_valid_o),
        .instr_o       (instr_o),
        .instr_ready_i (instr_ready_i)
    );

endmodule

//--- hdl/instr_queue.sv
// circular instruction queue taking up to two entries per cycle and releasing one
`timescale 1ns/10ps

module instr_queue #(
    // number of entries as a power of two of at least four
    parameter int unsigned QueueDepth = 8
) (
    input  logic                                                       clk_i,
    input  logic                                                       rst_ni,
    input  logic                                                       flush_i,
    input  logic                                                       push_i,
    input  logic [realign_pkg::InstrPerFetch-1:0]                      slot_valid_i,
    input  realign_pkg::instr_entry_t [realign_pkg::InstrPerFetch-1:0] slot_i,
    output logic                                                       space_o,
    output logic                                                       instr_valid_o,
    output realign_pkg::instr_entry_t                                  instr_o,
    input  logic                                                       instr_ready_i
);

    // --------------------
    // pointer types
    // --------------------

    localparam int unsigned PtrWidth = $clog2(QueueDepth);

    // index into the storage array that wraps naturally at the depth
    typedef logic [PtrWidth-1:0] ptr_t;
    // the fill level is one bit wider so that a full queue can be told apart
    typedef logic [PtrWidth:0]   cnt_t;

    // --------------------
    // storage and pointers
    // --------------------

    realign_pkg::instr_entry_t mem_q [QueueDepth];

    ptr_t wr_ptr_q;
    ptr_t rd_ptr_q;
    cnt_t count_q;

    // zero to two entries are written per cycle
    cnt_t push_cnt;
    // the head leaves on the output handshake
    logic pop;
    // slot 1 always lands right behind slot 0
    ptr_t wr_ptr_nxt;

    assign wr_ptr_nxt = wr_ptr_q + ptr_t'(1);

    always_comb begin
        push_cnt = '0;
        if (push_i) begin
            // slot 1 is only valid together with slot 0, so this counts in slot order
            push_cnt = cnt_t'(slot_valid_i[0]) + cnt_t'(slot_valid_i[1]);
        end
    end

    // --------------------
    // output port
    // --------------------

    assign instr_valid_o = (count_q != '0);
    assign instr_o       = mem_q[rd_ptr_q];
    assign pop           = instr_valid_o && instr_ready_i;

    // the fetch side may only send a word if both of its instructions fit
    assign space_o = (count_q <= cnt_t'(QueueDepth - 2));

    // --------------------
    // pointer and count update
    // --------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // drop everything regardless of the handshakes in this cycle
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + ptr_t'(push_cnt);
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + ptr_t'(1);
            end
            // push and pop in the same cycle net out here
            count_q <= count_q + push_cnt - cnt_t'(pop);
        end
    end

    // --------------------
    // entry write
    // --------------------

    // valid slots land at the write pointer in slot order
    always_ff @(posedge clk_i) begin
        if (push_i && slot_valid_i[0]) begin
            mem_q[wr_ptr_q] <= slot_i[0];
        end
        if (push_i && slot_valid_i[1]) begin
            mem_q[wr_ptr_nxt] <= slot_i[1];
        end
    end

endmodule

//--- hdl/instr_realign.sv
// instruction re-aligner that splits fetch words into compressed and full instructions
`timescale 1ns/10ps

module instr_realign #(
    // when cleared, every parcel is treated as the start of a full instruction
    parameter bit EnableRvc = 1'b1
) (
    input  logic                                                       clk_i,
    input  logic                                                       rst_ni,
    input  logic                                                       flush_i,
    input  logic                                                       fetch_accept_i,
    input  realign_pkg::fetch_req_t                                    fetch_req_i,
    output logic [realign_pkg::InstrPerFetch-1:0]                      slot_valid_o,
    output realign_pkg::instr_entry_t [realign_pkg::InstrPerFetch-1:0] slot_o
);

    // --------------------
    // parcel decode
    // --------------------

    // the two 16-bit parcels of the current beat
    realign_pkg::half_t lo_half;
    realign_pkg::half_t hi_half;
    // a parcel is compressed when its two low bits are not both one
    logic               lo_is_rvc;
    logic               hi_is_rvc;
    // the upper parcel sits two bytes above the word address
    realign_pkg::addr_t hi_addr;

    assign lo_half = fetch_req_i.data[realign_pkg::HalfWidth-1:0];
    assign hi_half = fetch_req_i.data[realign_pkg::InstrWidth-1:realign_pkg::HalfWidth];

    assign lo_is_rvc = EnableRvc && (lo_half[1:0] != 2'b11);
    assign hi_is_rvc = EnableRvc && (hi_half[1:0] != 2'b11);

    assign hi_addr = {fetch_req_i.addr[realign_pkg::AddrWidth-1:2], 2'b10};

    // --------------------
    // pending upper half
    // --------------------

    // set while the first half of a full instruction waits for the next word
    logic               pending_d;
    logic               pending_q;
    // the stored first parcel and the address of the instruction it begins
    realign_pkg::half_t pend_half_d;
    realign_pkg::half_t pend_half_q;
    realign_pkg::addr_t pend_addr_d;
    realign_pkg::addr_t pend_addr_q;

    // --------------------
    // alignment rules
    // --------------------

    always_comb begin
        // by default the pending state is kept as it is
        pending_d   = pending_q;
        pend_half_d = pend_half_q;
        pend_addr_d = pend_addr_q;

        // slot 0 defaults to the whole word at the beat address
        slot_valid_o    = '0;
        slot_o[0].addr  = fetch_req_i.addr;
        slot_o[0].instr = fetch_req_i.data;
        // slot 1 can only ever carry a compressed upper parcel
        slot_o[1].addr  = hi_addr;
        slot_o[1].instr = realign_pkg::instr_t'(hi_half);

        if (fetch_req_i.addr[1]) begin
            // entry at the upper halfword happens after a branch
            // the lower parcel belongs to code we jumped over and is ignored
            if (hi_is_rvc) begin
                slot_valid_o[0] = 1'b1;
                slot_o[0].instr = realign_pkg::instr_t'(hi_half);
                pending_d       = 1'b0;
            end else begin
                // only the first half is here, so wait for the next word
                pending_d   = 1'b1;
                pend_half_d = hi_half;
                pend_addr_d = fetch_req_i.addr;
            end
        end else if (pending_q || lo_is_rvc) begin
            // the lower parcel either completes the stored half or is a compressed instruction
            slot_valid_o[0] = 1'b1;
            if (pending_q) begin
                slot_o[0].instr = {lo_half, pend_half_q};
                slot_o[0].addr  = pend_addr_q;
            end else begin
                slot_o[0].instr = realign_pkg::instr_t'(lo_half);
            end

            // now look at the upper parcel on its own
            if (hi_is_rvc) begin
                slot_valid_o[1] = 1'b1;
                pending_d       = 1'b0;
            end else begin
                // a full instruction starts here and spans into the next word
                pending_d   = 1'b1;
                pend_half_d = hi_half;
                pend_addr_d = hi_addr;
            end
        end else begin
            // an aligned full instruction fills the whole word
            slot_valid_o[0] = 1'b1;
            pending_d       = 1'b0;
        end
    end

    // --------------------
    // state registers
    // --------------------

    // the flag only moves on accepted beats and is dropped on flush
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (flush_i) begin
            pending_q <= 1'b0;
        end else if (fetch_accept_i) begin
            pending_q <= pending_d;
        end
    end

    // stored first parcel and address of the pending instruction
    always_ff @(posedge clk_i) begin
        if (fetch_accept_i) begin
            pend_half_q <= pend_half_d;
            pend_addr_q <= pend_addr_d;
        end
    end

endmodule

//--- hdl/realign_pkg.sv
// shared widths, vector types and bundles for the RISC-V fetch re-alignment path
package realign_pkg;

    // --------------------
    // widths
    // --------------------

    // byte address of a fetch beat or of an extracted instruction
    localparam int unsigned AddrWidth = 64;
    // a full (uncompressed) instruction
    localparam int unsigned InstrWidth = 32;
    // one parcel, which is also the size of a compressed instruction
    localparam int unsigned HalfWidth = 16;
    // a 32-bit fetch block holds at most two instructions
    localparam int unsigned InstrPerFetch = 2;

    // --------------------
    // vector types
    // --------------------

    typedef logic [AddrWidth-1:0]  addr_t;
    // compressed instructions sit zero-extended in the lower half
    typedef logic [InstrWidth-1:0] instr_t;
    typedef logic [HalfWidth-1:0]  half_t;
    // the fetch block is exactly one full instruction wide
    typedef logic [InstrWidth-1:0] fetch_word_t;

    // --------------------
    // bundles
    // --------------------

    // one fetch beat as it arrives from the fetch side
    typedef struct packed {
        addr_t       addr;
        fetch_word_t data;
    } fetch_req_t;

    // one extracted instruction together with the address it lives at
    typedef struct packed {
        addr_t  addr;
        instr_t instr;
    } instr_entry_t;

endpackage
